/* design/xosera_pkg.sv */
// register map, XR map and small-mode video timing shared by the whole design
// XR address words decode as a register number or as a memory region plus offset
package xosera_pkg;

    // host register numbers
    localparam logic [3:0] XM_XR_ADDR  = 4'd0;     // XR address for XR_DATA
    localparam logic [3:0] XM_XR_DATA  = 4'd1;     // XR register or palette data
    localparam logic [3:0] XM_RD_ADDR  = 4'd2;     // VRAM read address
    localparam logic [3:0] XM_WR_ADDR  = 4'd3;     // VRAM write address
    localparam logic [3:0] XM_DATA     = 4'd4;     // VRAM data port
    localparam logic [3:0] XM_SYS_CTRL = 4'd5;     // nibble mask, status, intr mask
    localparam logic [3:0] XM_INTR_CLR = 4'd6;     // write 1s to clear status

    // XR register numbers
    localparam logic [4:0] XR_VID_CTRL   = 5'd0;   // bit 1 signals soft interrupt
    localparam logic [4:0] XR_DISP_START = 5'd1;   // first word of frame
    localparam logic [4:0] XR_LINE_LEN   = 5'd2;   // words between lines
    localparam logic [4:0] XR_SCANLINE   = 5'd3;   // current line, read only

    localparam logic [1:0] XR_COLOR_REGION = 2'd0; // palette region in memory view

    // small mode, in pixels and lines
    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 4;
    localparam int H_TOTAL   = 24;
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 12;

    // interrupt source bits
    localparam int INTR_VBLANK = 0;
    localparam int INTR_SOFT   = 1;

    // one XR address word, two views picked by bit 15
    typedef union packed {
        struct packed {
            logic       mem;        // 0 for register view
            logic [9:0] unused;
            logic [4:0] num;        // register number
        } regv;
        struct packed {
            logic        mem;       // 1 for memory view
            logic        spare;
            logic [1:0]  region;    // which XR memory
            logic [11:0] offset;    // word within region
        } memv;
    } xr_addr_t;

endpackage

/* design/xosera_reg_bus.sv */
// host side register file, one 16-bit word per pair of byte accesses
// high byte first, low byte write commits; VRAM requests wait while video owns VRAM
// host must leave 4 cycles after DATA or RD_ADDR writes before the next DATA access
`timescale 1ns/1ps

module xosera_reg_bus(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 bus_cs_n_i,       // access strobe, active low
    input  wire logic                 bus_rd_nwr_i,     // 1 read, 0 write
    input  wire logic                 bus_bytesel_i,    // 0 high byte, 1 low byte
    input  wire logic [3:0]           bus_reg_num_i,
    input  wire logic [7:0]           bus_data_i,
    output logic      [7:0]           bus_data_o,
    output logic                      bus_intr_o,
    input  wire logic                 vgen_busy_i,      // video owns VRAM this cycle
    input  wire logic [15:0]          vram_data_i,
    input  wire logic [15:0]          xr_data_i,        // video register readback
    input  wire logic [3:0]           intr_signal_i,
    output logic                      vram_req_o,       // held until granted
    output logic                      vram_wr_o,
    output logic      [3:0]           vram_mask_o,
    output logic      [15:0]          vram_addr_o,
    output logic      [15:0]          vram_wdata_o,
    output logic                      xr_reg_wr_o,      // one cycle strobes
    output logic                      color_wr_o,
    output xosera_pkg::xr_addr_t      xr_addr_o,
    output logic      [15:0]          xr_wdata_o
);

logic  [7:0] hi_byte;               // latched even byte
logic [15:0] rd_addr;
logic [15:0] wr_addr;
logic [15:0] rd_buf;                // read-ahead word
logic  [3:0] intr_mask;
logic  [3:0] intr_status;
logic  [3:0] intr_clear;
logic        wr_pend;
logic        rd_pend;
logic        rd_load;               // vram data valid for rd_buf
logic        bus_wr;
logic        bus_rd;
logic        commit;
logic [15:0] wr_word;
logic [15:0] rd_word;

assign bus_wr  = !bus_cs_n_i && !bus_rd_nwr_i;
assign bus_rd  = !bus_cs_n_i && bus_rd_nwr_i;
assign commit  = bus_wr && bus_bytesel_i;      // odd byte completes the word
assign wr_word = {hi_byte, bus_data_i};
assign intr_clear = (commit && bus_reg_num_i == xosera_pkg::XM_INTR_CLR) ?
                    wr_word[3:0] : 4'h0;

// write has priority, only one is expected at a time
assign vram_req_o  = wr_pend || rd_pend;
assign vram_wr_o   = wr_pend;
assign vram_addr_o = wr_pend ? wr_addr : rd_addr;

always_comb begin
    case (bus_reg_num_i)
        xosera_pkg::XM_XR_ADDR:  rd_word = xr_addr_o;
        xosera_pkg::XM_XR_DATA:  rd_word = xr_data_i;
        xosera_pkg::XM_RD_ADDR:  rd_word = rd_addr;
        xosera_pkg::XM_WR_ADDR:  rd_word = wr_addr;
        xosera_pkg::XM_DATA:     rd_word = rd_buf;
        xosera_pkg::XM_SYS_CTRL: rd_word = {4'h0, vram_mask_o, intr_status, intr_mask};
        xosera_pkg::XM_INTR_CLR: rd_word = {12'h0, intr_status};
        default:                 rd_word = 16'h0;
    endcase
end

// data path
always_ff @(posedge clk) begin
    if (bus_wr && !bus_bytesel_i) begin
        hi_byte <= bus_data_i;
    end
    if (commit && bus_reg_num_i == xosera_pkg::XM_XR_DATA) begin
        xr_wdata_o <= wr_word;
    end
    if (commit && bus_reg_num_i == xosera_pkg::XM_DATA) begin
        vram_wdata_o <= wr_word;
    end
    if (rd_load) begin
        rd_buf <= vram_data_i;
    end
    if (bus_rd) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        xr_addr_o   <= '0;
        rd_addr     <= 16'h0;
        wr_addr     <= 16'h0;
        vram_mask_o <= 4'h0;
        intr_mask   <= 4'h0;
        intr_status <= 4'h0;
        bus_intr_o  <= 1'b0;
        wr_pend     <= 1'b0;
        rd_pend     <= 1'b0;
        rd_load     <= 1'b0;
        xr_reg_wr_o <= 1'b0;
        color_wr_o  <= 1'b0;
    end else begin
        xr_reg_wr_o <= 1'b0;
        color_wr_o  <= 1'b0;
        rd_load     <= 1'b0;
        if (vram_req_o && !vgen_busy_i) begin      // granted
            if (wr_pend) begin
                wr_pend <= 1'b0;
                wr_addr <= wr_addr + 16'h1;         // auto-increment
            end else begin
                rd_pend <= 1'b0;
                rd_load <= 1'b1;
            end
        end
        if (commit) begin
            case (bus_reg_num_i)
                xosera_pkg::XM_XR_ADDR: xr_addr_o <= wr_word;
                xosera_pkg::XM_XR_DATA: begin
                    xr_reg_wr_o <= !xr_addr_o.regv.mem;
                    color_wr_o  <= xr_addr_o.memv.mem &&
                                   xr_addr_o.memv.region == xosera_pkg::XR_COLOR_REGION;
                end
                xosera_pkg::XM_RD_ADDR: begin
                    rd_addr <= wr_word;
                    rd_pend <= 1'b1;                // read ahead
                end
                xosera_pkg::XM_WR_ADDR: wr_addr <= wr_word;
                xosera_pkg::XM_DATA:    wr_pend <= 1'b1;
                xosera_pkg::XM_SYS_CTRL: begin
                    vram_mask_o <= wr_word[11:8];
                    intr_mask   <= wr_word[3:0];
                end
                default: ;
            endcase
        end
        // odd DATA read moves on and fetches the next word
        if (bus_rd && bus_bytesel_i && bus_reg_num_i == xosera_pkg::XM_DATA) begin
            rd_addr <= rd_addr + 16'h1;
            rd_pend <= 1'b1;
        end
        // pulse only for new, enabled sources
        bus_intr_o  <= |(intr_signal_i & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_signal_i) & ~intr_clear;
    end
end

endmodule

/* design/xosera_vram.sv */
// 64K x 16 single port VRAM, registered read
// video owns the port when selected and never writes; host writes only when video is idle
`timescale 1ns/1ps

module xosera_vram(
    input  wire logic        clk,
    input  wire logic        vgen_sel_i,      // video fetch this cycle
    input  wire logic [15:0] vgen_addr_i,
    input  wire logic        host_req_i,
    input  wire logic        host_wr_i,
    input  wire logic [3:0]  host_mask_i,     // one enable per nibble
    input  wire logic [15:0] host_addr_i,
    input  wire logic [15:0] host_wdata_i,
    output logic      [15:0] rdata_o
);

logic [15:0] mem [0:65535];
logic [15:0] addr;
logic        host_we;

assign addr    = vgen_sel_i ? vgen_addr_i : host_addr_i;   // video wins
assign host_we = !vgen_sel_i && host_req_i && host_wr_i;

always_ff @(posedge clk) begin
    if (host_we) begin
        for (int n = 0; n < 4; n++) begin
            if (host_mask_i[n]) begin
                mem[addr][n*4 +: 4] <= host_wdata_i[n*4 +: 4];   // disabled nibbles keep old
            end
        end
    end
    rdata_o <= mem[addr];       // old data on write cycle
end

endmodule

/* design/xosera_video_gen.sv */
// small-mode timing, one VRAM word fetched per two pixels on even visible pixels
// pixel 2k is the high byte of word k; syncs and enable leave 2 cycles behind the counters
// line stride is LINE_LEN words starting at DISP_START, latched at frame end
`timescale 1ns/1ps

module xosera_video_gen(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 xr_reg_wr_i,
    input  xosera_pkg::xr_addr_t      xr_addr_i,
    input  wire logic [15:0]          xr_wdata_i,
    input  wire logic [15:0]          vram_data_i,
    output logic      [15:0]          xr_data_o,
    output logic      [3:0]           intr_signal_o,
    output logic                      vram_sel_o,
    output logic      [15:0]          vram_addr_o,
    output logic      [7:0]           color_index_o,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic                      dv_de_o
);

logic  [4:0] h_count;
logic  [3:0] v_count;
logic [15:0] disp_start;
logic [15:0] line_len;
logic [15:0] line_base;             // first word of current line
logic        h_vis;
logic        v_vis;
logic        h_end;
logic        hs_n;
logic        vs_n;
logic  [1:0] hs_d;
logic  [1:0] vs_d;
logic  [1:0] de_d;
logic        sel_d;                 // vram data is ours
logic        odd_d;                 // odd pixel phase
logic  [7:0] lo_byte;               // held for the odd pixel

assign h_vis = h_count < 5'(xosera_pkg::H_VISIBLE);
assign v_vis = v_count < 4'(xosera_pkg::V_VISIBLE);
assign h_end = h_count == 5'(xosera_pkg::H_TOTAL - 1);
assign hs_n  = !(h_count >= 5'(xosera_pkg::H_VISIBLE + xosera_pkg::H_FRONT) &&
                 h_count < 5'(xosera_pkg::H_VISIBLE + xosera_pkg::H_FRONT + xosera_pkg::H_SYNC));
assign vs_n  = !(v_count >= 4'(xosera_pkg::V_VISIBLE + xosera_pkg::V_FRONT) &&
                 v_count < 4'(xosera_pkg::V_VISIBLE + xosera_pkg::V_FRONT + xosera_pkg::V_SYNC));

assign vram_sel_o    = h_vis && v_vis && !h_count[0];
assign vram_addr_o   = line_base + 16'(h_count[4:1]);
assign color_index_o = odd_d ? lo_byte : vram_data_i[15:8];
assign hsync_o       = hs_d[1];
assign vsync_o       = vs_d[1];
assign dv_de_o       = de_d[1];

always_comb begin
    xr_data_o = 16'h0;
    if (!xr_addr_i.regv.mem) begin
        case (xr_addr_i.regv.num)
            xosera_pkg::XR_DISP_START: xr_data_o = disp_start;
            xosera_pkg::XR_LINE_LEN:   xr_data_o = line_len;
            xosera_pkg::XR_SCANLINE:   xr_data_o = {12'h0, v_count};
            default:                   xr_data_o = 16'h0;  // VID_CTRL write only
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count       <= 5'h0;
        v_count       <= 4'h0;
        line_base     <= 16'h0;
        disp_start    <= 16'h0;
        line_len      <= 16'(xosera_pkg::H_VISIBLE / 2);
        hs_d          <= 2'b11;
        vs_d          <= 2'b11;
        de_d          <= 2'b00;
        intr_signal_o <= 4'h0;
    end else begin
        h_count <= h_end ? 5'h0 : h_count + 5'h1;
        if (h_end) begin
            if (v_count == 4'(xosera_pkg::V_TOTAL - 1)) begin
                v_count   <= 4'h0;
                line_base <= disp_start;            // new frame
            end else begin
                v_count   <= v_count + 4'h1;
                line_base <= line_base + line_len;
            end
        end
        hs_d <= {hs_d[0], hs_n};
        vs_d <= {vs_d[0], vs_n};
        de_d <= {de_d[0], h_vis && v_vis};
        intr_signal_o <= 4'h0;
        // line V_VISIBLE starts next cycle
        intr_signal_o[xosera_pkg::INTR_VBLANK] <=
            h_end && v_count == 4'(xosera_pkg::V_VISIBLE - 1);
        if (xr_reg_wr_i) begin
            case (xr_addr_i.regv.num)
                xosera_pkg::XR_VID_CTRL:   intr_signal_o[xosera_pkg::INTR_SOFT] <= xr_wdata_i[1];
                xosera_pkg::XR_DISP_START: disp_start <= xr_wdata_i;
                xosera_pkg::XR_LINE_LEN:   line_len   <= xr_wdata_i;
                default: ;
            endcase
        end
    end
end

// pixel select pipeline
always_ff @(posedge clk) begin
    sel_d <= vram_sel_o;
    odd_d <= h_count[0];
    if (sel_d) begin
        lo_byte <= vram_data_i[7:0];    // host may reuse vram next cycle
    end
end

endmodule

/* design/xosera_color_out.sv */
// 256 x 12 palette, registered read, then reset-cleared RGB and sync register
// index arrives one cycle ahead of syncs and enable; RGB forced to 0 outside display
`timescale 1ns/1ps

module xosera_color_out(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        color_wr_i,
    input  wire logic [7:0]  color_addr_i,
    input  wire logic [15:0] color_wdata_i,   // 0RGB, top nibble ignored
    input  wire logic [7:0]  color_index_i,
    input  wire logic        hsync_i,
    input  wire logic        vsync_i,
    input  wire logic        dv_de_i,
    output logic      [3:0]  red_o,
    output logic      [3:0]  green_o,
    output logic      [3:0]  blue_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             dv_de_o
);

logic [11:0] palette [0:255];
logic [11:0] pal_rd;

always_ff @(posedge clk) begin
    if (color_wr_i) begin
        palette[color_addr_i] <= color_wdata_i[11:0];
    end
    pal_rd <= palette[color_index_i];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        red_o   <= 4'h0;
        green_o <= 4'h0;
        blue_o  <= 4'h0;
        hsync_o <= 1'b1;        // syncs idle high
        vsync_o <= 1'b1;
        dv_de_o <= 1'b0;
    end else begin
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
        dv_de_o <= dv_de_i;
        red_o   <= dv_de_i ? pal_rd[11:8] : 4'h0;   // blank
        green_o <= dv_de_i ? pal_rd[7:4]  : 4'h0;
        blue_o  <= dv_de_i ? pal_rd[3:0]  : 4'h0;
    end
end

endmodule

/* design/xosera_main.sv */
// bitmap video controller top, 8-bit host bus and 4-bit RGB out
// video output lags the timing counters by 3 cycles; syncs active low
`timescale 1ns/1ps

module xosera_main(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        bus_cs_n_i,
    input  wire logic        bus_rd_nwr_i,
    input  wire logic        bus_bytesel_i,
    input  wire logic [3:0]  bus_reg_num_i,
    input  wire logic [7:0]  bus_data_i,
    output logic      [7:0]  bus_data_o,
    output logic             bus_intr_o,
    output logic      [3:0]  red_o,
    output logic      [3:0]  green_o,
    output logic      [3:0]  blue_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             dv_de_o
);

logic                 vgen_sel;       // video owns vram
logic [15:0]          vgen_addr;
logic [15:0]          vram_rdata;
logic                 host_req;
logic                 host_wr;
logic  [3:0]          host_mask;
logic [15:0]          host_addr;
logic [15:0]          host_wdata;
logic                 xr_reg_wr;
logic                 color_wr;
xosera_pkg::xr_addr_t xr_addr;
logic [15:0]          xr_wdata;
logic [15:0]          xr_rdata;
logic  [3:0]          intr_signal;
logic  [7:0]          color_index;
logic                 vg_hsync;       // 2 cycles behind counters
logic                 vg_vsync;
logic                 vg_de;

xosera_reg_bus reg_bus(
    .clk(clk),                  .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_data_i(bus_data_i),    .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o),
    .vgen_busy_i(vgen_sel),     .vram_data_i(vram_rdata),
    .xr_data_i(xr_rdata),       .intr_signal_i(intr_signal),
    .vram_req_o(host_req),      .vram_wr_o(host_wr),
    .vram_mask_o(host_mask),    .vram_addr_o(host_addr),
    .vram_wdata_o(host_wdata),
    .xr_reg_wr_o(xr_reg_wr),    .color_wr_o(color_wr),
    .xr_addr_o(xr_addr),        .xr_wdata_o(xr_wdata)
);

xosera_vram vram(
    .clk(clk),
    .vgen_sel_i(vgen_sel),      .vgen_addr_i(vgen_addr),
    .host_req_i(host_req),      .host_wr_i(host_wr),
    .host_mask_i(host_mask),    .host_addr_i(host_addr),
    .host_wdata_i(host_wdata),  .rdata_o(vram_rdata)
);

xosera_video_gen video_gen(
    .clk(clk),                  .reset_i(reset_i),
    .xr_reg_wr_i(xr_reg_wr),    .xr_addr_i(xr_addr),
    .xr_wdata_i(xr_wdata),      .vram_data_i(vram_rdata),
    .xr_data_o(xr_rdata),       .intr_signal_o(intr_signal),
    .vram_sel_o(vgen_sel),      .vram_addr_o(vgen_addr),
    .color_index_o(color_index),
    .hsync_o(vg_hsync),         .vsync_o(vg_vsync),
    .dv_de_o(vg_de)
);

// palette offset is the low byte of the memory view
xosera_color_out color_out(
    .clk(clk),                  .reset_i(reset_i),
    .color_wr_i(color_wr),      .color_addr_i(xr_addr[7:0]),
    .color_wdata_i(xr_wdata),   .color_index_i(color_index),
    .hsync_i(vg_hsync),         .vsync_i(vg_vsync),
    .dv_de_i(vg_de),
    .red_o(red_o),              .green_o(green_o),
    .blue_o(blue_o),
    .hsync_o(hsync_o),          .vsync_o(vsync_o),
    .dv_de_o(dv_de_o)
);

endmodule

/* test/xosera_assert.sv */
// bus interrupt pulse width, blanking and sync/enable overlap on the top level
// checks are off while reset is held
`timescale 1ns/1ps

module xosera_assert(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_intr_i,
    input  wire logic [3:0] red_i,
    input  wire logic [3:0] green_i,
    input  wire logic [3:0] blue_i,
    input  wire logic       hsync_i,
    input  wire logic       de_i
);

// interrupt is a single cycle pulse
intr_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
    bus_intr_i |=> !bus_intr_i)
    else $error("bus_intr_o high two cycles running");

// no color outside the display window
rgb_blank: assert property (@(posedge clk) disable iff (reset_i)
    !de_i |-> (red_i == 4'h0 && green_i == 4'h0 && blue_i == 4'h0))
    else $error("RGB not zero while dv_de_o low");

hsync_outside_de: assert property (@(posedge clk) disable iff (reset_i)
    !(de_i && !hsync_i))
    else $error("dv_de_o high during hsync");

endmodule

bind xosera_main xosera_assert assert_i(
    .clk(clk),              .reset_i(reset_i),
    .bus_intr_i(bus_intr_o),
    .red_i(red_o),          .green_i(green_o),
    .blue_i(blue_o),
    .hsync_i(hsync_o),      .de_i(dv_de_o)
);

/* test/xosera_tests.svh */
// directed tests, included inside xosera_tb
// each task drives the bus, checks against the models and reports one line

task automatic test_vram_rw();
    int start;
    start = errors;
    set_masks(4'hF, 4'h0);
    set_write_addr(16'h0040);
    for (int i = 0; i < 16; i++) begin
        vram_write(rand_bits(16));
    end
    check_vram(16'h0040, 16);         // read back with increment
    report_test("vram_rw", start);
endtask

task automatic test_nibble_mask();
    int start;
    start = errors;
    set_masks(4'hF, 4'h0);
    set_write_addr(16'h0200);
    vram_write(rand_bits(16));        // known old data
    vram_write(rand_bits(16));
    set_masks(4'b0101, 4'h0);
    set_write_addr(16'h0200);
    vram_write(rand_bits(16));
    set_masks(4'b1010, 4'h0);
    vram_write(rand_bits(16));        // next word, other nibbles
    check_vram(16'h0200, 2);
    set_masks(4'hF, 4'h0);
    report_test("nibble_mask", start);
endtask

task automatic test_xr_regs();
    int          start;
    logic [15:0] disp;
    logic [15:0] len;
    logic  [7:0] hi;
    logic  [7:0] lo;
    start = errors;
    disp = rand_bits(16);
    len  = rand_bits(16);
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_DISP_START});
    write_reg(xosera_pkg::XM_XR_DATA, disp);
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_LINE_LEN});
    write_reg(xosera_pkg::XM_XR_DATA, len);
    check_read(xosera_pkg::XM_XR_DATA, len, "LINE_LEN");
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_DISP_START});
    check_read(xosera_pkg::XM_XR_DATA, disp, "DISP_START");
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_SCANLINE});
    read_reg(xosera_pkg::XM_XR_DATA, hi, lo);
    check_byte("SCANLINE high", hi, 8'h00);
    check_bit("SCANLINE below V_TOTAL", lo < 8'(xosera_pkg::V_TOTAL), 1'b1);
    report_test("xr_regs", start);
endtask

task automatic test_pixels();
    int          start;
    int          disp;
    int          len;
    logic [15:0] word;
    logic [15:0] addr;
    logic  [7:0] idx;
    logic [11:0] color;
    start = errors;
    disp  = 'h100;
    len   = xosera_pkg::H_VISIBLE / 2;
    for (int i = 0; i < 256; i++) begin
        word = rand_bits(12);
        pal_model[i] = word[11:0];
        write_reg(xosera_pkg::XM_XR_ADDR, {8'h80, 8'(i)});     // memory view, color region
        write_reg(xosera_pkg::XM_XR_DATA, {4'h0, word[11:0]});
    end
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_DISP_START});
    write_reg(xosera_pkg::XM_XR_DATA, 16'(disp));
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_LINE_LEN});
    write_reg(xosera_pkg::XM_XR_DATA, 16'(len));
    set_write_addr(16'(disp));
    for (int i = 0; i < len * xosera_pkg::V_VISIBLE; i++) begin
        vram_write(rand_bits(16));
    end
    // frame after vsync uses the new start
    wait_level(SIG_VSYNC, 1'b0, 700, "vsync low");
    wait_level(SIG_VSYNC, 1'b1, 100, "vsync high");
    for (int l = 0; l < xosera_pkg::V_VISIBLE; l++) begin
        wait_level(SIG_DE, 1'b1, 100, "display enable");
        for (int p = 0; p < xosera_pkg::H_VISIBLE; p++) begin
            if (p > 0) @(negedge clk);
            addr  = 16'(disp + l * len + p / 2);
            word  = vram_model[addr];
            idx   = (p % 2 == 1) ? word[7:0] : word[15:8];   // even pixel is high byte
            color = pal_model[idx];
            check_bit($sformatf("dv_de_o line %0d pixel %0d", l, p), de, 1'b1);
            check_nibble($sformatf("red_o line %0d pixel %0d", l, p), red, color[11:8]);
            check_nibble($sformatf("green_o line %0d pixel %0d", l, p), green, color[7:4]);
            check_nibble($sformatf("blue_o line %0d pixel %0d", l, p), blue, color[3:0]);
        end
        @(negedge clk);
        check_bit($sformatf("dv_de_o end of line %0d", l), de, 1'b0);
    end
    report_test("pixels", start);
endtask

task automatic test_timing();
    int   start;
    int   last_fall;
    int   run;
    int   lines;
    int   falls;
    int   vs_low;
    logic prev_h;
    logic prev_de;
    start = errors;
    last_fall = -1;
    run    = 0;
    lines  = 0;
    falls  = 0;
    vs_low = 0;
    wait_level(SIG_VSYNC, 1'b1, 700, "vsync high");
    wait_level(SIG_VSYNC, 1'b0, 700, "vsync low");
    prev_h  = hsync;
    prev_de = de;
    for (int c = 1; c <= xosera_pkg::V_TOTAL * xosera_pkg::H_TOTAL; c++) begin
        @(negedge clk);
        if (prev_h && !hsync) begin
            if (last_fall >= 0) check_count("hsync period", c - last_fall, xosera_pkg::H_TOTAL);
            last_fall = c;
            falls++;
        end
        if (!vsync) vs_low++;
        if (de) run++;
        if (de && !prev_de) lines++;
        if (!de && prev_de) begin
            check_count("dv_de_o cycles per line", run, xosera_pkg::H_VISIBLE);
            run = 0;
        end
        prev_h  = hsync;
        prev_de = de;
    end
    check_count("hsync_o falls per frame", falls, xosera_pkg::V_TOTAL);
    check_count("vsync_o low cycles per frame", vs_low,
                xosera_pkg::V_SYNC * xosera_pkg::H_TOTAL);
    check_count("visible lines per frame", lines, xosera_pkg::V_VISIBLE);
    report_test("timing", start);
endtask

task automatic test_interrupts();
    int         start;
    int         pulses;
    logic [7:0] hi;
    logic [7:0] lo;
    start = errors;
    set_masks(4'hF, 4'b0010);         // soft on, vblank off
    write_reg(xosera_pkg::XM_XR_ADDR, {11'h0, xosera_pkg::XR_VID_CTRL});
    write_reg(xosera_pkg::XM_XR_DATA, 16'h0002);
    wait_level(SIG_INTR, 1'b1, 20, "soft interrupt pulse");
    @(negedge clk);
    check_bit("bus_intr_o after pulse", intr, 1'b0);
    read_reg(xosera_pkg::XM_SYS_CTRL, hi, lo);
    check_bit("soft status set", lo[4 + xosera_pkg::INTR_SOFT], 1'b1);
    // already in status, so no new pulse
    pulses = 0;
    write_reg(xosera_pkg::XM_XR_DATA, 16'h0002);
    for (int c = 0; c < 20; c++) begin
        @(negedge clk);
        if (intr) pulses++;
    end
    check_count("pulses on repeat soft write", pulses, 0);
    write_reg(xosera_pkg::XM_INTR_CLR, 16'h0002);
    read_reg(xosera_pkg::XM_SYS_CTRL, hi, lo);
    check_bit("soft status cleared", lo[4 + xosera_pkg::INTR_SOFT], 1'b0);
    // earlier frames left vblank in status, so only the mask can hold it off
    write_reg(xosera_pkg::XM_INTR_CLR, 16'h0001);
    pulses = 0;
    for (int c = 0; c < xosera_pkg::V_TOTAL * xosera_pkg::H_TOTAL + 24; c++) begin
        @(negedge clk);
        if (intr) pulses++;
    end
    check_count("pulses with vblank masked", pulses, 0);
    report_test("interrupts", start);
endtask

/* test/xosera_tb.sv */
// directed testbench for xosera_main, 100 ns clock, inputs change on the rising edge
// outputs sampled on the falling edge; host leaves 4 idle cycles after VRAM accesses
`timescale 1ns/1ps

module xosera_tb;

localparam int SIG_VSYNC = 0;
localparam int SIG_DE    = 1;
localparam int SIG_INTR  = 2;

logic        clk;
logic        reset_i;
logic        cs_n;
logic        rd_nwr;
logic        bytesel;
logic  [3:0] reg_num;
logic  [7:0] data_in;
logic  [7:0] data_out;
logic        intr;
logic  [3:0] red;
logic  [3:0] green;
logic  [3:0] blue;
logic        hsync;
logic        vsync;
logic        de;

logic [15:0] vram_model [0:65535];   // expected VRAM words
logic [11:0] pal_model [0:255];      // expected palette
logic [31:0] lfsr_state = 32'd96890;
logic [15:0] wr_ptr;                 // model copy of WR_ADDR
logic  [3:0] cur_mask;               // model copy of nibble mask
int          errors = 0;
int          tests_run = 0;
int          tests_failed = 0;

xosera_main dut(
    .clk(clk),                  .reset_i(reset_i),
    .bus_cs_n_i(cs_n),          .bus_rd_nwr_i(rd_nwr),
    .bus_bytesel_i(bytesel),    .bus_reg_num_i(reg_num),
    .bus_data_i(data_in),       .bus_data_o(data_out),
    .bus_intr_o(intr),
    .red_o(red),                .green_o(green),
    .blue_o(blue),
    .hsync_o(hsync),            .vsync_o(vsync),
    .dv_de_o(de)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = 16'h0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[14:0], fb};
    end
    return v;
endfunction

// masked nibbles take the new word
function automatic logic [15:0] merge_nibbles(input logic [15:0] old_w,
                                              input logic [15:0] new_w,
                                              input logic [3:0] mask);
    logic [15:0] r;
    r = old_w;
    for (int n = 0; n < 4; n++) begin
        if (mask[n]) r[n*4 +: 4] = new_w[n*4 +: 4];
    end
    return r;
endfunction

function automatic logic probe(input int sel);
    case (sel)
        SIG_VSYNC: return vsync;
        SIG_DE:    return de;
        default:   return intr;
    endcase
endfunction

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        errors++;
    end
endtask

task automatic idle(input int n);
    repeat (n) @(posedge clk);
endtask

// wait on an output level, polled on falling edges
task automatic wait_level(input int sel, input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(sel) !== level && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (probe(sel) !== level) begin
        $display("timeout waiting for %s", what);
        errors++;
    end
endtask

// high byte then low byte, commit on the low byte
task automatic write_reg(input logic [3:0] num, input logic [15:0] word);
    @(posedge clk);
    cs_n    <= 1'b0;
    rd_nwr  <= 1'b0;
    bytesel <= 1'b0;
    reg_num <= num;
    data_in <= word[15:8];
    @(posedge clk);
    bytesel <= 1'b1;
    data_in <= word[7:0];
    @(posedge clk);
    cs_n    <= 1'b1;
    rd_nwr  <= 1'b1;
endtask

task automatic read_reg(input logic [3:0] num, output logic [7:0] hi, output logic [7:0] lo);
    @(posedge clk);
    cs_n    <= 1'b0;
    rd_nwr  <= 1'b1;
    bytesel <= 1'b0;
    reg_num <= num;
    @(posedge clk);
    bytesel <= 1'b1;
    @(negedge clk);
    hi = data_out;              // one cycle after the strobe
    @(posedge clk);
    cs_n    <= 1'b1;
    @(negedge clk);
    lo = data_out;
endtask

task automatic check_read(input logic [3:0] num, input logic [15:0] exp, input string name);
    logic [7:0] hi;
    logic [7:0] lo;
    read_reg(num, hi, lo);
    check_byte({name, " high"}, hi, exp[15:8]);
    check_byte({name, " low"}, lo, exp[7:0]);
endtask

task automatic set_masks(input logic [3:0] nib_mask, input logic [3:0] intr_mask);
    write_reg(xosera_pkg::XM_SYS_CTRL, {4'h0, nib_mask, 4'h0, intr_mask});
    cur_mask = nib_mask;
endtask

task automatic set_write_addr(input logic [15:0] addr);
    write_reg(xosera_pkg::XM_WR_ADDR, addr);
    wr_ptr = addr;
endtask

task automatic vram_write(input logic [15:0] word);
    write_reg(xosera_pkg::XM_DATA, word);
    vram_model[wr_ptr] = merge_nibbles(vram_model[wr_ptr], word, cur_mask);
    wr_ptr = wr_ptr + 16'h1;
    idle(4);
endtask

// read-ahead from addr, DATA reads increment
task automatic check_vram(input logic [15:0] addr, input int count);
    logic [15:0] a;
    a = addr;
    write_reg(xosera_pkg::XM_RD_ADDR, addr);
    idle(4);
    for (int i = 0; i < count; i++) begin
        check_read(xosera_pkg::XM_DATA, vram_model[a], $sformatf("vram[%h]", a));
        a = a + 16'h1;
        idle(4);
    end
endtask

task automatic report_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", name, errors - start);
    end
endtask

`include "xosera_tests.svh"

initial begin
    reset_i <= 1'b1;
    cs_n    <= 1'b1;
    rd_nwr  <= 1'b1;
    bytesel <= 1'b0;
    reg_num <= 4'h0;
    data_in <= 8'h00;
    wr_ptr   = 16'h0;
    cur_mask = 4'h0;
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;
    idle(2);
    test_vram_rw();
    test_nibble_mask();
    test_xr_regs();
    test_pixels();
    test_timing();
    test_interrupts();
    $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

/* xosera_lite.f */
+incdir+test
design/xosera_pkg.sv
design/xosera_reg_bus.sv
design/xosera_vram.sv
design/xosera_video_gen.sv
design/xosera_color_out.sv
design/xosera_main.sv
test/xosera_assert.sv
test/xosera_tb.sv

/* Makefile */
# Verilator build and run of the xosera_lite testbench
.PHONY: all compile run clean

all: run

compile: obj_dir/Vxosera_tb

obj_dir/Vxosera_tb: xosera_lite.f design/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert --top-module xosera_tb -f xosera_lite.f

# a crash or a reported failure both give a failing status
run: obj_dir/Vxosera_tb
	./obj_dir/Vxosera_tb > sim.log 2>&1; st=$$?; cat sim.log; \
	if [ $$st -ne 0 ] || grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
